// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_frame_fetch
FILELIST  = filelist.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/sdram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
	input  wire logic                       clk,
	input  wire logic                       reset_n,
	input  wire logic                       slow,
	input  wire frame_fetch_pkg::avm_cmd_t  avm,
	output logic                            waitrequest,
	output logic                            readdatavalid,
	output frame_fetch_pkg::mem_word_t      readdata
);

	import frame_fetch_pkg::*;

	int         stall_left;
	int         resp_left;
	logic       in_request;
	word_addr_t req_addr;

	// every address gives a distinct word, low 24 bits included.
	function automatic mem_word_t scramble(input word_addr_t a);
		mem_word_t x;
		x = 32'(a);
		return (x * 32'h9e3779b1) + (x << 7);
	endfunction

	always @(negedge clk or negedge reset_n) begin
		if (!reset_n) begin
			waitrequest   <= 1'b1;
			readdatavalid <= 1'b0;
			readdata      <= '0;
			stall_left = 0;
			resp_left  = 0;
			in_request = 1'b0;
			req_addr   = '0;
		end else begin
			readdatavalid <= 1'b0;
			waitrequest   <= 1'b1;
			if (!waitrequest) begin
				in_request = 1'b0; // taken at the last rising edge.
				resp_left  = $urandom_range(1, 3);
			end else if (avm.read) begin
				if (!in_request) begin
					in_request = 1'b1;
					req_addr   = avm.address;
					stall_left = slow ? 40 : $urandom_range(0, 2);
				end
				if (stall_left == 0) begin
					waitrequest <= 1'b0;
				end else begin
					stall_left = stall_left - 1;
				end
			end
			if (resp_left > 0) begin
				resp_left = resp_left - 1;
				if (resp_left == 0) begin
					readdatavalid <= 1'b1;
					readdata      <= scramble(req_addr);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_frame_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frame_fetch;

	import frame_fetch_pkg::*;

	localparam int line_cycles = (frame_width + h_sync_len + h_back_len + h_front_len) * pixel_div;

	logic       clk;
	logic       reset_n;
	logic       pll_locked;
	logic       slow;
	logic       waitrequest;
	logic       readdatavalid;
	mem_word_t  readdata;
	avm_cmd_t   avm;
	video_out_t video;
	logic       underrun;

	logic lock_phase;
	logic fast_check;
	logic timed_out;
	int   mism;
	int   other;
	int   accepted;
	int   returned;
	int   returned_q;
	int   returned_qq;
	int   pix_idx;
	int   underrun_cnt;
	int   phase;
	logic act_q;
	logic first_cycle;
	logic h_q;
	logic v_q;
	logic h_seen;
	logic v_seen;
	int   h_period;
	int   h_high;
	int   line_pix;
	int   frame_lines;

	frame_fetch_top i_frame_fetch_top (
		.clk           (clk),
		.reset_n       (reset_n),
		.pll_locked    (pll_locked),
		.waitrequest   (waitrequest),
		.readdatavalid (readdatavalid),
		.readdata      (readdata),
		.avm           (avm),
		.video         (video),
		.underrun      (underrun)
	);

	sdram_model i_sdram_model (
		.clk           (clk),
		.reset_n       (reset_n),
		.slow          (slow),
		.avm           (avm),
		.waitrequest   (waitrequest),
		.readdatavalid (readdatavalid),
		.readdata      (readdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// pixel k comes from address frame_base + k mod frame_pixels.
	function automatic pixel_t expected_pixel(input int idx);
		mem_word_t a;
		mem_word_t w;
		a = 32'(frame_base) + 32'(idx % frame_pixels);
		w = (a * 32'h9e3779b1) + (a << 7);
		return w[23:0];
	endfunction

	function automatic word_addr_t expected_addr(input int n);
		return frame_base + word_addr_t'(n % frame_pixels);
	endfunction

	assign first_cycle = video.active && (!act_q || phase == 0); // new slot on the output.

	always @(posedge clk or negedge reset_n) begin
		int lines_now;
		if (!reset_n) begin
			accepted <= 0;
			returned <= 0;
			returned_q <= 0;
			returned_qq <= 0;
			pix_idx <= 0;
			underrun_cnt <= 0;
			phase <= 0;
			act_q <= 1'b0;
			h_q <= 1'b0;
			v_q <= 1'b0;
			h_seen <= 1'b0;
			v_seen <= 1'b0;
			h_period <= 0;
			h_high <= 0;
			line_pix <= 0;
			frame_lines <= 0;
		end else begin
			act_q <= video.active;
			h_q <= video.hsync;
			v_q <= video.vsync;
			returned <= returned + (readdatavalid ? 1 : 0);
			returned_q <= returned;
			returned_qq <= returned_q; // a returned word can be popped two edges later.
			if (video.active && !act_q) begin
				phase <= 1;
			end else begin
				phase <= (phase == pixel_div - 1) ? 0 : phase + 1;
			end
			if (avm.read && !waitrequest) begin
				assert (avm.address == expected_addr(accepted)) else begin
					mism++;
					$display("mismatch avm.address: got %h expected %h",
						avm.address, expected_addr(accepted));
				end
				accepted <= accepted + 1;
			end
			if (first_cycle) begin
				line_pix <= line_pix + 1;
				if (returned_qq == pix_idx) begin
					// fifo held no word when this slot began.
					assert (underrun) else begin
						mism++;
						$display("mismatch underrun: got %h expected %h", underrun, 1'b1);
					end
					assert (video.pixel == '0) else begin
						mism++;
						$display("mismatch video.pixel: got %h expected %h", video.pixel, 24'h0);
					end
					underrun_cnt <= underrun_cnt + 1;
				end else begin
					assert (!underrun) else begin
						mism++;
						$display("mismatch underrun: got %h expected %h", underrun, 1'b0);
					end
					assert (video.pixel == expected_pixel(pix_idx)) else begin
						mism++;
						$display("mismatch video.pixel: got %h expected %h",
							video.pixel, expected_pixel(pix_idx));
					end
					pix_idx <= pix_idx + 1;
				end
			end
			if (video.hsync && !h_q) begin
				if (h_seen) begin
					assert (h_period == line_cycles) else begin
						mism++;
						$display("mismatch hsync period: got %h expected %h",
							h_period, line_cycles);
					end
				end
				h_seen <= 1'b1;
				h_period <= 1;
				h_high <= 1;
				if (line_pix != 0) begin
					assert (line_pix == frame_width) else begin
						mism++;
						$display("mismatch active pixels per line: got %h expected %h",
							line_pix, frame_width);
					end
				end
				lines_now = frame_lines + ((line_pix != 0) ? 1 : 0);
				line_pix <= 0;
				if (video.vsync && !v_q) begin
					if (v_seen) begin
						assert (lines_now == frame_height) else begin
							mism++;
							$display("mismatch active lines per frame: got %h expected %h",
								lines_now, frame_height);
						end
					end
					v_seen <= 1'b1;
					frame_lines <= 0;
				end else begin
					frame_lines <= lines_now;
				end
			end else begin
				h_period <= h_period + 1;
				if (video.hsync) begin
					h_high <= h_high + 1;
				end
			end
			if (!video.hsync && h_q) begin
				assert (h_high == h_sync_len * pixel_div) else begin
					mism++;
					$display("mismatch hsync width: got %h expected %h",
						h_high, h_sync_len * pixel_div);
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		avm.read && waitrequest |=> avm.read && $stable(avm.address))
	else begin
		other++;
		$display("read request dropped or address changed before acceptance");
	end

	assert property (@(posedge clk) disable iff (!reset_n) avm.chipselect == avm.read)
	else begin
		other++;
		$display("chipselect does not follow read");
	end

	assert property (@(posedge clk) disable iff (!reset_n) avm.byteenable == 4'hf)
	else begin
		mism++;
		$display("mismatch avm.byteenable: got %h expected %h", avm.byteenable, 4'hf);
	end

	assert property (@(posedge clk) disable iff (!reset_n)
		lock_phase |-> !avm.read && !avm.chipselect && !video.active)
	else begin
		other++;
		$display("activity seen before the pll locked");
	end

	assert property (@(posedge clk) disable iff (!reset_n) accepted - pix_idx <= fifo_depth + 1)
	else begin
		other++;
		$display("reader ran more than a fifo ahead of the video output");
	end

	assert property (@(posedge clk) disable iff (!reset_n) underrun |-> first_cycle)
	else begin
		other++;
		$display("underrun pulse outside the start of an active slot");
	end

	assert property (@(posedge clk) disable iff (!reset_n) fast_check |-> !underrun)
	else begin
		other++;
		$display("underrun while memory was fast");
	end

	task automatic report_timeout(input string what);
		other++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	initial begin
		int t;
		int start_idx;
		void'($urandom(32'h73c6));
		reset_n = 1'b0;
		pll_locked = 1'b0;
		slow = 1'b0;
		lock_phase = 1'b1;
		fast_check = 1'b0;
		timed_out = 1'b0;
		mism = 0;
		other = 0;
		repeat (3) @(negedge clk);
		reset_n = 1'b1;
		repeat (50) @(negedge clk);
		pll_locked = 1'b1;
		lock_phase = 1'b0;

		for (t = 0; t < 5000 && !video.active; t++) @(negedge clk);
		if (!video.active) report_timeout("the first active pixel");

		if (!timed_out) begin
			fast_check = 1'b1; // two whole frames with no underrun.
			for (t = 0; t < 20000 && pix_idx < 2 * frame_pixels; t++) @(negedge clk);
			if (pix_idx < 2 * frame_pixels) report_timeout("two frames of pixels");
			fast_check = 1'b0;
		end

		if (!timed_out) begin
			slow <= 1'b1;
			for (t = 0; t < 20000 && underrun_cnt < 4; t++) @(negedge clk);
			if (underrun_cnt < 4) report_timeout("underrun pulses in slow mode");
			slow <= 1'b0;
		end

		if (!timed_out) begin
			start_idx = pix_idx;
			for (t = 0; t < 30000 && pix_idx < start_idx + frame_pixels; t++) @(negedge clk);
			if (pix_idx < start_idx + frame_pixels) report_timeout("pixels after slow mode");
		end

		$display("checks done: %0d mismatches, %0d other errors", mism, other);
		if (mism == 0 && other == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/frame_fetch_pkg.sv
src/frame_reader.sv
src/pixel_fifo.sv
src/video_timing.sv
src/frame_fetch_top.sv
bench/sdram_model.sv
bench/tb_frame_fetch.sv

// ==== src/frame_fetch_pkg.sv ====
`default_nettype none

package frame_fetch_pkg;

	typedef logic [29:0] word_addr_t; // avalon word address.
	typedef logic [31:0] mem_word_t;
	typedef logic [23:0] pixel_t; // rgb, low 24 bits of a word.
	typedef logic [3:0]  fifo_level_t; // 0 .. fifo_depth.

	typedef enum logic [1:0] {
		idle,
		wait_read,
		write_fifo
	} reader_state_t;

	localparam word_addr_t frame_base = 30'h0004_0000;
	localparam int frame_width  = 16;
	localparam int frame_height = 8;
	localparam int frame_pixels = frame_width * frame_height;

	localparam int h_sync_len  = 2;
	localparam int h_back_len  = 2;
	localparam int h_front_len = 2;
	localparam int v_sync_len  = 1;
	localparam int v_back_len  = 1;
	localparam int v_front_len = 1;

	// full line and frame length in pixel slots and lines
	localparam int h_total = h_sync_len + h_back_len + frame_width + h_front_len;
	localparam int v_total = v_sync_len + v_back_len + frame_height + v_front_len;

	localparam int pixel_div     = 16; // clk cycles per pixel slot.
	localparam int fifo_depth    = 8;
	localparam int prefill_level = 4;

	typedef struct packed {
		logic       read;
		logic       chipselect;
		logic [3:0] byteenable;
		word_addr_t address;
	} avm_cmd_t;

	typedef struct packed {
		logic   hsync;
		logic   vsync;
		logic   active;
		pixel_t pixel;
	} video_out_t;

endpackage

`default_nettype wire

// ==== src/frame_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fetch_top (
	input  wire logic                       clk,
	input  wire logic                       reset_n,
	input  wire logic                       pll_locked,
	input  wire logic                       waitrequest,
	input  wire logic                       readdatavalid,
	input  wire frame_fetch_pkg::mem_word_t readdata,
	output frame_fetch_pkg::avm_cmd_t       avm,
	output frame_fetch_pkg::video_out_t     video,
	output logic                            underrun
);

	import frame_fetch_pkg::*;

	logic        fifo_wr_en;
	pixel_t      fifo_wr_data;
	logic        fifo_rd_en;
	pixel_t      fifo_rd_data;
	logic        fifo_full;
	logic        fifo_empty;
	fifo_level_t fifo_level;

	frame_reader i_frame_reader (
		.clk           (clk),
		.reset_n       (reset_n),
		.pll_locked    (pll_locked),
		.waitrequest   (waitrequest),
		.readdatavalid (readdatavalid),
		.readdata      (readdata),
		.avm           (avm),
		.fifo_full     (fifo_full),
		.fifo_wr_en    (fifo_wr_en),
		.fifo_wr_data  (fifo_wr_data)
	);

	pixel_fifo i_pixel_fifo (
		.clk     (clk),
		.reset_n (reset_n),
		.wr_en   (fifo_wr_en),
		.wr_data (fifo_wr_data),
		.rd_en   (fifo_rd_en),
		.rd_data (fifo_rd_data),
		.full    (fifo_full),
		.empty   (fifo_empty),
		.level   (fifo_level)
	);

	video_timing i_video_timing (
		.clk          (clk),
		.reset_n      (reset_n),
		.fifo_level   (fifo_level),
		.fifo_empty   (fifo_empty),
		.fifo_rd_en   (fifo_rd_en),
		.fifo_rd_data (fifo_rd_data),
		.video        (video),
		.underrun     (underrun)
	);

endmodule

`default_nettype wire

// ==== src/frame_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_reader (
	input  wire logic                     clk,
	input  wire logic                     reset_n,
	input  wire logic                     pll_locked,
	input  wire logic                     waitrequest,
	input  wire logic                     readdatavalid,
	input  wire frame_fetch_pkg::mem_word_t readdata,
	output frame_fetch_pkg::avm_cmd_t     avm,
	input  wire logic                     fifo_full,
	output logic                          fifo_wr_en,
	output frame_fetch_pkg::pixel_t       fifo_wr_data
);

	import frame_fetch_pkg::*;

	reader_state_t state;
	word_addr_t    pix_cnt; // index of the next pixel to fetch.
	logic          started;
	logic          data_arrives;

	// read already accepted once read has dropped inside wait_read
	assign data_arrives = (state == wait_read) && !avm.read && readdatavalid;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			started <= 1'b0;
		end else if (pll_locked) begin
			started <= 1'b1; // stays set after first lock.
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state          <= idle;
			pix_cnt        <= '0;
			fifo_wr_en     <= 1'b0;
			avm.read       <= 1'b0;
			avm.chipselect <= 1'b0;
			avm.byteenable <= 4'hf;
			avm.address    <= frame_base;
		end else begin
			fifo_wr_en <= 1'b0;

			case (state)
				idle: begin
					if (started && !fifo_full) begin
						avm.read       <= 1'b1;
						avm.chipselect <= 1'b1;
						avm.address    <= frame_base + pix_cnt;
						state          <= wait_read;
					end
				end

				wait_read: begin
					if (avm.read && !waitrequest) begin
						avm.read       <= 1'b0; // slave took the request.
						avm.chipselect <= 1'b0;
					end
					if (data_arrives) begin
						fifo_wr_en <= 1'b1;
						state      <= write_fifo;
						if (pix_cnt == word_addr_t'(frame_pixels - 1)) begin
							pix_cnt <= '0;
						end else begin
							pix_cnt <= pix_cnt + 1'b1;
						end
					end
				end

				write_fifo: begin
					state <= idle; // one spare cycle before the next read.
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (data_arrives) begin
			fifo_wr_data <= readdata[23:0];
		end
	end

endmodule

`default_nettype wire

// ==== src/pixel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
	input  wire logic                    clk,
	input  wire logic                    reset_n,
	input  wire logic                    wr_en,
	input  wire frame_fetch_pkg::pixel_t wr_data,
	input  wire logic                    rd_en,
	output frame_fetch_pkg::pixel_t      rd_data,
	output logic                         full,
	output logic                         empty,
	output frame_fetch_pkg::fifo_level_t level
);

	import frame_fetch_pkg::*;

	pixel_t mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	logic push;
	logic pop;

	assign full    = (level == fifo_level_t'(fifo_depth));
	assign empty   = (level == '0);
	assign push    = wr_en && !full;
	assign pop     = rd_en && !empty;
	assign rd_data = mem[rd_ptr]; // head word is always on show.

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ($clog2(fifo_depth))'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ($clog2(fifo_depth))'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // both or neither.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing (
	input  wire logic                         clk,
	input  wire logic                         reset_n,
	input  wire frame_fetch_pkg::fifo_level_t fifo_level,
	input  wire logic                         fifo_empty,
	output logic                              fifo_rd_en,
	input  wire frame_fetch_pkg::pixel_t      fifo_rd_data,
	output frame_fetch_pkg::video_out_t       video,
	output logic                              underrun
);

	import frame_fetch_pkg::*;

	logic running;
	logic [$clog2(pixel_div)-1:0] div_cnt;
	logic [$clog2(h_total)-1:0]   h_cnt;
	logic [$clog2(v_total)-1:0]   v_cnt;
	logic slot;
	logic h_active;
	logic v_active;
	logic in_active;

	assign slot = running && (div_cnt == ($clog2(pixel_div))'(pixel_div - 1));

	// sync first, then back porch, active region, front porch
	assign h_active = (h_cnt >= h_sync_len + h_back_len) &&
	                  (h_cnt <  h_sync_len + h_back_len + frame_width);
	assign v_active = (v_cnt >= v_sync_len + v_back_len) &&
	                  (v_cnt <  v_sync_len + v_back_len + frame_height);
	assign in_active = h_active && v_active;

	assign fifo_rd_en = slot && in_active && !fifo_empty;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			running  <= 1'b0;
			div_cnt  <= '0;
			h_cnt    <= '0;
			v_cnt    <= '0;
			video    <= '0;
			underrun <= 1'b0;
		end else begin
			underrun <= slot && in_active && fifo_empty;
			if (fifo_level >= fifo_level_t'(prefill_level)) begin
				running <= 1'b1; // never clears, timing runs on regardless.
			end
			if (running) begin
				div_cnt <= slot ? '0 : div_cnt + 1'b1;
			end
			if (slot) begin
				video.hsync  <= (h_cnt < h_sync_len);
				video.vsync  <= (v_cnt < v_sync_len);
				video.active <= in_active;
				video.pixel  <= fifo_rd_en ? fifo_rd_data : '0;
				if (h_cnt == ($clog2(h_total))'(h_total - 1)) begin
					h_cnt <= '0;
					v_cnt <= (v_cnt == ($clog2(v_total))'(v_total - 1)) ? '0 : v_cnt + 1'b1;
				end else begin
					h_cnt <= h_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire
